// File: source/queue_pkg.sv
package queue_pkg;

    // queue and register page geometry
    localparam int NB_QUEUES         = 4;
    localparam int QUEUE_IDX_WIDTH   = $clog2(NB_QUEUES);
    localparam int RB_AWIDTH         = 16;
    localparam int DWORD_WIDTH       = 32;
    localparam int REGS_PER_PAGE     = 4;
    localparam int PAGE_BYTES_WIDTH  = REGS_PER_PAGE * DWORD_WIDTH / 8;

    // cycles from a table read enable to its data
    localparam int BRAM_READ_LATENCY = 2;

    typedef logic [QUEUE_IDX_WIDTH-1:0] queue_idx_t;
    typedef logic [RB_AWIDTH-1:0]       rb_ptr_t;
    typedef logic [DWORD_WIDTH-1:0]     dword_t;
    typedef logic [2*DWORD_WIDTH-1:0]   kmem_addr_t;

    // table fields, in page dword order
    typedef enum logic [1:0] {
        TAIL      = 2'd0,
        HEAD      = 2'd1,
        KMEM_LOW  = 2'd2,
        KMEM_HIGH = 2'd3
    } table_field_e;

    // one PIO access to a queue page
    typedef struct packed {
        logic                                   wr;
        queue_idx_t                             page;
        logic [REGS_PER_PAGE*DWORD_WIDTH-1:0]   wr_data;
        logic [PAGE_BYTES_WIDTH-1:0]            byte_en;
    } pio_req_t;

    // fields changed by a PIO write
    typedef struct packed {
        queue_idx_t queue;
        logic       head_vld;
        rb_ptr_t    head;
        logic       kmem_low_vld;
        dword_t     kmem_low;
        logic       kmem_high_vld;
        dword_t     kmem_high;
    } pio_update_t;

    // state of the queue the ring buffer currently fills
    typedef struct packed {
        queue_idx_t id;
        rb_ptr_t    head;
        rb_ptr_t    tail;
        kmem_addr_t kmem_addr;
    } queue_state_t;

endpackage

// File: source/queue_table_ram.sv
`timescale 1ns/1ps

module queue_table_ram #(
    parameter type data_t = queue_pkg::dword_t
) (
    input  logic                  pcie_clk,
    input  queue_pkg::queue_idx_t addr_a,
    input  queue_pkg::queue_idx_t addr_b,
    input  logic                  wr_en_a,
    input  logic                  wr_en_b,
    input  logic                  rd_en_a,
    input  logic                  rd_en_b,
    input  data_t                 wr_data_a,
    input  data_t                 wr_data_b,
    output data_t                 rd_data_a,
    output data_t                 rd_data_b
);
    import queue_pkg::*;

    data_t mem [NB_QUEUES] = '{default: '0};
    data_t pipe_a [BRAM_READ_LATENCY];
    data_t pipe_b [BRAM_READ_LATENCY];

    // port A and port B never hit the same entry in one cycle
    always_ff @(posedge pcie_clk) begin
        if (wr_en_a) begin
            mem[addr_a] <= wr_data_a;
        end
        if (wr_en_b) begin
            mem[addr_b] <= wr_data_b;
        end
    end

    // first stage samples the array on a read, later stages just shift
    always_ff @(posedge pcie_clk) begin
        if (rd_en_a) begin
            pipe_a[0] <= mem[addr_a];
        end
        if (rd_en_b) begin
            pipe_b[0] <= mem[addr_b];
        end
        for (int i = 1; i < BRAM_READ_LATENCY; i++) begin
            pipe_a[i] <= pipe_a[i-1];
            pipe_b[i] <= pipe_b[i-1];
        end
    end

    assign rd_data_a = pipe_a[BRAM_READ_LATENCY-1];
    assign rd_data_b = pipe_b[BRAM_READ_LATENCY-1];

endmodule

// File: source/pio_regs.sv
`timescale 1ns/1ps

module pio_regs (
    input  logic                   pcie_clk,
    input  logic                   pcie_reset_n,
    input  logic                   pio_valid,
    input  queue_pkg::pio_req_t    pio_req,
    // head table, port B
    output queue_pkg::queue_idx_t  head_addr_b,
    output logic                   head_wr_en_b,
    output logic                   head_rd_en_b,
    output queue_pkg::rb_ptr_t     head_wr_data_b,
    // kmem low table, port B
    output queue_pkg::queue_idx_t  kmem_low_addr_b,
    output logic                   kmem_low_wr_en_b,
    output logic                   kmem_low_rd_en_b,
    output queue_pkg::dword_t      kmem_low_wr_data_b,
    // kmem high table, port B
    output queue_pkg::queue_idx_t  kmem_high_addr_b,
    output logic                   kmem_high_wr_en_b,
    output logic                   kmem_high_rd_en_b,
    output queue_pkg::dword_t      kmem_high_wr_data_b,
    // tail table is read only from this side
    output queue_pkg::queue_idx_t  tail_addr_b,
    output logic                   tail_rd_en_b,
    input  queue_pkg::rb_ptr_t     tail_rd_data_b,
    input  queue_pkg::rb_ptr_t     head_rd_data_b,
    input  queue_pkg::dword_t      kmem_low_rd_data_b,
    input  queue_pkg::dword_t      kmem_high_rd_data_b,
    output logic                   pio_readdata_valid,
    output logic [queue_pkg::REGS_PER_PAGE*queue_pkg::DWORD_WIDTH-1:0] pio_readdata,
    output logic                   update_valid,
    output queue_pkg::pio_update_t update
);
    import queue_pkg::*;

    dword_t                       wr_dword [REGS_PER_PAGE];
    logic [REGS_PER_PAGE-1:0]     dword_full;
    logic                         is_write;
    logic                         is_read;
    queue_idx_t                   page_r;
    logic                         rd_en_r;
    logic [BRAM_READ_LATENCY-1:0] rd_pipe;

    // a dword counts only when all of its byte enables are set
    always_comb begin
        for (int i = 0; i < REGS_PER_PAGE; i++) begin
            wr_dword[i]   = pio_req.wr_data[i*DWORD_WIDTH +: DWORD_WIDTH];
            dword_full[i] = &pio_req.byte_en[i*(DWORD_WIDTH/8) +: DWORD_WIDTH/8];
        end
    end

    assign is_write = pio_valid && pio_req.wr;
    assign is_read  = pio_valid && !pio_req.wr;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            head_wr_en_b      <= 1'b0;
            kmem_low_wr_en_b  <= 1'b0;
            kmem_high_wr_en_b <= 1'b0;
            update_valid      <= 1'b0;
            rd_en_r           <= 1'b0;
            rd_pipe           <= '0;
        end else begin
            // dword 0 is the tail, owned by the FPGA side
            head_wr_en_b      <= is_write && dword_full[HEAD];
            kmem_low_wr_en_b  <= is_write && dword_full[KMEM_LOW];
            kmem_high_wr_en_b <= is_write && dword_full[KMEM_HIGH];
            update_valid      <= is_write && (|dword_full[REGS_PER_PAGE-1:1]);
            rd_en_r           <= is_read;
            // follows the read through the table latency
            rd_pipe <= {rd_pipe[BRAM_READ_LATENCY-2:0], rd_en_r};
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pio_valid) begin
            page_r              <= pio_req.page;
            head_wr_data_b      <= wr_dword[HEAD][RB_AWIDTH-1:0];
            kmem_low_wr_data_b  <= wr_dword[KMEM_LOW];
            kmem_high_wr_data_b <= wr_dword[KMEM_HIGH];
            update.queue         <= pio_req.page;
            update.head_vld      <= dword_full[HEAD];
            update.head          <= wr_dword[HEAD][RB_AWIDTH-1:0];
            update.kmem_low_vld  <= dword_full[KMEM_LOW];
            update.kmem_low      <= wr_dword[KMEM_LOW];
            update.kmem_high_vld <= dword_full[KMEM_HIGH];
            update.kmem_high     <= wr_dword[KMEM_HIGH];
        end
    end

    // all four tables share the page address
    assign tail_addr_b      = page_r;
    assign head_addr_b      = page_r;
    assign kmem_low_addr_b  = page_r;
    assign kmem_high_addr_b = page_r;

    assign tail_rd_en_b      = rd_en_r;
    assign head_rd_en_b      = rd_en_r;
    assign kmem_low_rd_en_b  = rd_en_r;
    assign kmem_high_rd_en_b = rd_en_r;

    assign pio_readdata_valid = rd_pipe[BRAM_READ_LATENCY-1];

    // page layout, tail in the lowest dword
    assign pio_readdata = {
        kmem_high_rd_data_b,
        kmem_low_rd_data_b,
        dword_t'(head_rd_data_b),
        dword_t'(tail_rd_data_b)
    };

endmodule

// File: source/queue_switcher.sv
`timescale 1ns/1ps

module queue_switcher (
    input  logic                               pcie_clk,
    input  logic                               pcie_reset_n,
    input  logic [queue_pkg::QUEUE_IDX_WIDTH:0] nb_queues,
    input  logic                               dma_done,
    input  queue_pkg::rb_ptr_t                 new_tail,
    input  logic                               update_valid,
    input  queue_pkg::pio_update_t             update,
    // tail table, port A
    output queue_pkg::queue_idx_t              tail_addr_a,
    output logic                               tail_wr_en_a,
    output logic                               tail_rd_en_a,
    output queue_pkg::rb_ptr_t                 tail_wr_data_a,
    input  queue_pkg::rb_ptr_t                 tail_rd_data_a,
    // head table, port A
    output queue_pkg::queue_idx_t              head_addr_a,
    output logic                               head_rd_en_a,
    input  queue_pkg::rb_ptr_t                 head_rd_data_a,
    // kmem low table, port A
    output queue_pkg::queue_idx_t              kmem_low_addr_a,
    output logic                               kmem_low_rd_en_a,
    input  queue_pkg::dword_t                  kmem_low_rd_data_a,
    // kmem high table, port A
    output queue_pkg::queue_idx_t              kmem_high_addr_a,
    output logic                               kmem_high_rd_en_a,
    input  queue_pkg::dword_t                  kmem_high_rd_data_a,
    output queue_pkg::queue_state_t            active
);
    import queue_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DELAY_1,
        DELAY_2,
        SWITCH
    } state_e;

    state_e                   state;
    logic [QUEUE_IDX_WIDTH:0] id_plus_one;
    queue_idx_t               next_id;
    queue_idx_t               fetch_addr;
    logic                     fetch_rd_en;
    logic                     multi_queue;
    logic                     update_hit;

    // round robin over the configured queues
    assign id_plus_one = {1'b0, active.id} + 1'b1;
    assign next_id     = (id_plus_one >= nb_queues) ? '0 : id_plus_one[QUEUE_IDX_WIDTH-1:0];
    assign multi_queue = nb_queues > 1;
    assign update_hit  = update_valid && (update.queue == active.id);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state        <= IDLE;
            fetch_rd_en  <= 1'b0;
            tail_wr_en_a <= 1'b0;
            active       <= '0;
        end else begin
            fetch_rd_en  <= 1'b0;
            tail_wr_en_a <= 1'b0;

            // CPU wrote the page of the queue in use
            if (update_hit) begin
                if (update.head_vld) begin
                    active.head <= update.head;
                end
                if (update.kmem_low_vld) begin
                    active.kmem_addr[DWORD_WIDTH-1:0] <= update.kmem_low;
                end
                if (update.kmem_high_vld) begin
                    active.kmem_addr[2*DWORD_WIDTH-1:DWORD_WIDTH] <= update.kmem_high;
                end
            end

            case (state)
                IDLE: begin
                    // ring buffer spaces its strobes, extra ones are dropped
                    if (dma_done) begin
                        fetch_rd_en <= 1'b1;
                        active.tail <= new_tail;
                        state       <= DELAY_1;
                    end
                end
                DELAY_1: begin
                    state <= DELAY_2;
                end
                DELAY_2: begin
                    state <= SWITCH;
                end
                SWITCH: begin
                    tail_wr_en_a <= 1'b1;
                    // a single queue keeps its own running tail
                    if (multi_queue) begin
                        active.tail <= tail_rd_data_a;
                    end
                    active.head      <= head_rd_data_a;
                    active.kmem_addr <= {kmem_high_rd_data_a, kmem_low_rd_data_a};
                    active.id        <= next_id;
                    state            <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // prefetch goes to the next queue, write-back to the one being left
    always_ff @(posedge pcie_clk) begin
        if (state == IDLE && dma_done) begin
            fetch_addr  <= next_id;
            tail_addr_a <= next_id;
        end else if (state == SWITCH) begin
            tail_addr_a    <= active.id;
            tail_wr_data_a <= active.tail;
        end
    end

    assign head_addr_a      = fetch_addr;
    assign kmem_low_addr_a  = fetch_addr;
    assign kmem_high_addr_a = fetch_addr;

    assign tail_rd_en_a      = fetch_rd_en;
    assign head_rd_en_a      = fetch_rd_en;
    assign kmem_low_rd_en_a  = fetch_rd_en;
    assign kmem_high_rd_en_a = fetch_rd_en;

endmodule

// File: source/pcie_queue_top.sv
`timescale 1ns/1ps

module pcie_queue_top (
    input  logic                               pcie_clk,
    input  logic                               pcie_reset_n,
    input  logic [queue_pkg::QUEUE_IDX_WIDTH:0] nb_queues,
    input  logic                               pio_valid,
    input  queue_pkg::pio_req_t                pio_req,
    input  logic                               dma_done,
    input  queue_pkg::rb_ptr_t                 new_tail,
    output logic                               pio_readdata_valid,
    output logic [queue_pkg::REGS_PER_PAGE*queue_pkg::DWORD_WIDTH-1:0] pio_readdata,
    output queue_pkg::queue_state_t            active
);
    import queue_pkg::*;

    // tail table
    queue_idx_t tail_addr_a;
    logic       tail_wr_en_a;
    logic       tail_rd_en_a;
    rb_ptr_t    tail_wr_data_a;
    rb_ptr_t    tail_rd_data_a;
    queue_idx_t tail_addr_b;
    logic       tail_rd_en_b;
    rb_ptr_t    tail_rd_data_b;

    // head table
    queue_idx_t head_addr_a;
    logic       head_rd_en_a;
    rb_ptr_t    head_rd_data_a;
    queue_idx_t head_addr_b;
    logic       head_wr_en_b;
    logic       head_rd_en_b;
    rb_ptr_t    head_wr_data_b;
    rb_ptr_t    head_rd_data_b;

    // kmem address tables
    queue_idx_t kmem_low_addr_a;
    logic       kmem_low_rd_en_a;
    dword_t     kmem_low_rd_data_a;
    queue_idx_t kmem_low_addr_b;
    logic       kmem_low_wr_en_b;
    logic       kmem_low_rd_en_b;
    dword_t     kmem_low_wr_data_b;
    dword_t     kmem_low_rd_data_b;
    queue_idx_t kmem_high_addr_a;
    logic       kmem_high_rd_en_a;
    dword_t     kmem_high_rd_data_a;
    queue_idx_t kmem_high_addr_b;
    logic       kmem_high_wr_en_b;
    logic       kmem_high_rd_en_b;
    dword_t     kmem_high_wr_data_b;
    dword_t     kmem_high_rd_data_b;

    logic        update_valid;
    pio_update_t update;

    // the CPU has no write path to the tails
    queue_table_ram #(.data_t(rb_ptr_t)) tail_table (
        .pcie_clk (pcie_clk),
        .addr_a (tail_addr_a),           .addr_b (tail_addr_b),
        .wr_en_a (tail_wr_en_a),         .wr_en_b (1'b0),
        .rd_en_a (tail_rd_en_a),         .rd_en_b (tail_rd_en_b),
        .wr_data_a (tail_wr_data_a),     .wr_data_b ('0),
        .rd_data_a (tail_rd_data_a),     .rd_data_b (tail_rd_data_b)
    );

    // switcher only reads these three
    queue_table_ram #(.data_t(rb_ptr_t)) head_table (
        .pcie_clk (pcie_clk),
        .addr_a (head_addr_a),           .addr_b (head_addr_b),
        .wr_en_a (1'b0),                 .wr_en_b (head_wr_en_b),
        .rd_en_a (head_rd_en_a),         .rd_en_b (head_rd_en_b),
        .wr_data_a ('0),                 .wr_data_b (head_wr_data_b),
        .rd_data_a (head_rd_data_a),     .rd_data_b (head_rd_data_b)
    );

    queue_table_ram #(.data_t(dword_t)) kmem_low_table (
        .pcie_clk (pcie_clk),
        .addr_a (kmem_low_addr_a),       .addr_b (kmem_low_addr_b),
        .wr_en_a (1'b0),                 .wr_en_b (kmem_low_wr_en_b),
        .rd_en_a (kmem_low_rd_en_a),     .rd_en_b (kmem_low_rd_en_b),
        .wr_data_a ('0),                 .wr_data_b (kmem_low_wr_data_b),
        .rd_data_a (kmem_low_rd_data_a), .rd_data_b (kmem_low_rd_data_b)
    );

    queue_table_ram #(.data_t(dword_t)) kmem_high_table (
        .pcie_clk (pcie_clk),
        .addr_a (kmem_high_addr_a),       .addr_b (kmem_high_addr_b),
        .wr_en_a (1'b0),                  .wr_en_b (kmem_high_wr_en_b),
        .rd_en_a (kmem_high_rd_en_a),     .rd_en_b (kmem_high_rd_en_b),
        .wr_data_a ('0),                  .wr_data_b (kmem_high_wr_data_b),
        .rd_data_a (kmem_high_rd_data_a), .rd_data_b (kmem_high_rd_data_b)
    );

    pio_regs pio0 (.*);

    queue_switcher switcher0 (.*);

endmodule

// File: test/queue_checker.sv
`timescale 1ns/1ps

module queue_checker (
    input logic                pcie_clk,
    input logic                pcie_reset_n,
    input logic                pio_valid,
    input queue_pkg::pio_req_t pio_req,
    input logic                dma_done,
    input logic                pio_readdata_valid,
    input logic                tail_wr_en_a
);
    import queue_pkg::*;

    int assert_fails = 0;

    // read data comes back three cycles after the request
    read_latency: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pio_valid && !pio_req.wr |-> ##3 pio_readdata_valid)
        else begin
            assert_fails++;
            $error("read data did not return three cycles after a read strobe");
        end

    no_spurious_read: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pio_readdata_valid |-> $past(pio_valid && !pio_req.wr, 3))
        else begin
            assert_fails++;
            $error("read data valid without a read strobe three cycles before");
        end

    // ring buffer must leave the switcher time to finish
    dma_spacing: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_done |=> !dma_done [*3])
        else begin
            assert_fails++;
            $error("dma_done arrived while a queue switch was running");
        end

    // only the write-back of a queue switch touches the tail table
    tail_write_after_switch: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        tail_wr_en_a |-> $past(dma_done, 4))
        else begin
            assert_fails++;
            $error("tail table written without a queue switch four cycles before");
        end

endmodule

bind pcie_queue_top queue_checker checker0 (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .pio_valid          (pio_valid),
    .pio_req            (pio_req),
    .dma_done           (dma_done),
    .pio_readdata_valid (pio_readdata_valid),
    .tail_wr_en_a       (tail_wr_en_a)
);

// File: test/queue_scoreboard.sv
`timescale 1ns/1ps

module queue_scoreboard (
    input  logic                    pcie_clk,
    input  logic                    pcie_reset_n,
    input  logic                    pio_readdata_valid,
    input  logic [127:0]            pio_readdata,
    input  queue_pkg::queue_state_t active,
    input  logic                    exp_valid,
    input  logic                    exp_is_read,
    input  logic [8*24-1:0]         exp_name,
    input  logic [127:0]            exp_data,
    input  queue_pkg::queue_state_t exp_state,
    output int                      pass_count,
    output int                      fail_count,
    output int                      pending
);
    import queue_pkg::*;

    logic [8*24-1:0] name_q [$];
    logic [127:0]    data_q [$];
    int              passes = 0;
    int              fails = 0;

    assign pass_count = passes;
    assign fail_count = fails;
    assign pending    = name_q.size();

    task automatic report(input logic [8*24-1:0] name, input logic [127:0] expected,
                          input logic [127:0] actual);
        if (expected === actual) begin
            passes++;
            $display("PASS %0s", name);
        end else begin
            fails++;
            $display("ERR %0s expected %h actual %h", name, expected, actual);
        end
    endtask

    always @(posedge pcie_clk) begin
        logic [8*24-1:0] name;
        logic [127:0]    data;
        if (pcie_reset_n) begin
            // active state checks compare right away
            if (exp_valid && !exp_is_read) begin
                report(exp_name, 128'(exp_state), 128'(active));
            end
            if (exp_valid && exp_is_read) begin
                name_q.push_back(exp_name);
                data_q.push_back(exp_data);
            end
            // readback pairs with the oldest outstanding read
            if (pio_readdata_valid) begin
                if (name_q.size() == 0) begin
                    fails++;
                    $display("read data returned with no read outstanding");
                end else begin
                    name = name_q.pop_front();
                    data = data_q.pop_front();
                    report(name, data, pio_readdata);
                end
            end
        end
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import queue_pkg::*;

    localparam int MAX_CASES = 64;

    logic                       pcie_clk = 1'b0;
    logic                       pcie_reset_n = 1'b0;
    logic [QUEUE_IDX_WIDTH:0]   nb_queues = 4;
    logic                       pio_valid = 1'b0;
    pio_req_t                   pio_req = '0;
    logic                       dma_done = 1'b0;
    rb_ptr_t                    new_tail = '0;
    logic                       pio_readdata_valid;
    logic [127:0]               pio_readdata;
    queue_state_t               active;

    logic                       exp_valid = 1'b0;
    logic                       exp_is_read = 1'b0;
    logic [8*24-1:0]            exp_name = '0;
    logic [127:0]               exp_data = '0;
    queue_state_t               exp_state = '0;
    int                         pass_count;
    int                         fail_count;
    int                         pending;

    logic [8*24-1:0]          c_name [MAX_CASES];
    logic [8*8-1:0]           c_op [MAX_CASES];
    logic [QUEUE_IDX_WIDTH:0] c_nbq [MAX_CASES];
    queue_idx_t               c_page [MAX_CASES];
    logic [31:0]              c_wr [MAX_CASES][4];
    logic [15:0]              c_be [MAX_CASES];
    logic [15:0]              c_tail [MAX_CASES];
    logic [31:0]              c_exp [MAX_CASES][4];
    int                       n_cases = 0;
    int                       seed = 76;
    int                       tb_errors = 0;
    logic                     loaded = 1'b0;

    always #20 pcie_clk = ~pcie_clk;

    pcie_queue_top dut0 (.*);

    queue_scoreboard sb0 (.*);

    task automatic load_cases();
        int               fd;
        int               n;
        logic [8*256-1:0] line;
        fd = $fopen("test/queue_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/queue_cases.txt");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0 && n_cases < MAX_CASES) begin
                n = $sscanf(line, "%s %s %d %d %h %h %h %h %h %h %h %h %h %h",
                    c_name[n_cases], c_op[n_cases], c_nbq[n_cases], c_page[n_cases],
                    c_wr[n_cases][3], c_wr[n_cases][2], c_wr[n_cases][1],
                    c_wr[n_cases][0], c_be[n_cases], c_tail[n_cases],
                    c_exp[n_cases][3], c_exp[n_cases][2], c_exp[n_cases][1],
                    c_exp[n_cases][0]);
                // comment and blank lines do not parse fully
                if (n == 14) begin
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int i);
        int   k;
        logic got;
        nb_queues <= c_nbq[i];
        pio_req.wr      <= (c_op[i] == "WRITE");
        pio_req.page    <= c_page[i];
        // the tail dword is never stored, so its data is arbitrary
        pio_req.wr_data <= {c_wr[i][3], c_wr[i][2], c_wr[i][1], 32'($random(seed))};
        pio_req.byte_en <= c_be[i];
        exp_name        <= c_name[i];
        exp_data        <= {c_exp[i][3], c_exp[i][2], c_exp[i][1], c_exp[i][0]};
        exp_state       <= '{id: c_page[i], head: c_exp[i][1][15:0],
                             tail: c_exp[i][0][15:0], kmem_addr: {c_exp[i][3], c_exp[i][2]}};
        if (c_op[i] == "WRITE") begin
            pio_valid <= 1'b1;
            @(posedge pcie_clk);
            pio_valid <= 1'b0;
            // a following check sees active two cycles after the strobe
            @(posedge pcie_clk);
        end else if (c_op[i] == "READ") begin
            pio_valid   <= 1'b1;
            exp_valid   <= 1'b1;
            exp_is_read <= 1'b1;
            @(posedge pcie_clk);
            pio_valid <= 1'b0;
            exp_valid <= 1'b0;
            got = 1'b0;
            for (k = 0; k < 8 && !got; k++) begin
                @(posedge pcie_clk);
                got = pio_readdata_valid;
            end
            if (!got) begin
                tb_errors++;
                $display("no read data returned for test %0s", c_name[i]);
            end
        end else if (c_op[i] == "DMA") begin
            dma_done <= 1'b1;
            new_tail <= c_tail[i];
            @(posedge pcie_clk);
            dma_done <= 1'b0;
            // a following check sees active four cycles after the strobe
            repeat (3) @(posedge pcie_clk);
        end else begin
            exp_valid   <= 1'b1;
            exp_is_read <= 1'b0;
            @(posedge pcie_clk);
            exp_valid <= 1'b0;
            @(posedge pcie_clk);
        end
    endtask

    initial begin
        load_cases();
        loaded = 1'b1;
        repeat (16) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
        @(posedge pcie_clk);
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        repeat (4) @(posedge pcie_clk);
        if (pending != 0) begin
            tb_errors++;
            $display("%0d reads still waiting for data at the end", pending);
        end
        $display("tests passed %0d, failed %0d, assertion failures %0d, other errors %0d",
                 pass_count, fail_count, dut0.checker0.assert_fails, tb_errors);
        if (fail_count == 0 && tb_errors == 0 && dut0.checker0.assert_fails == 0
                && pass_count > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog sized from the number of cases
    initial begin
        wait (loaded);
        repeat (n_cases * 10 + 16) @(posedge pcie_clk);
        $display("timeout: the tests did not finish within %0d cycles", n_cases * 10 + 16);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: test/queue_cases.txt
# columns: name op nb_queues page wr3 wr2 wr1 wr0 byte_en new_tail exp3 exp2 exp1 exp0
# READ expects the page dwords, CHECK expects active as id=page head=exp1 tail=exp0 kmem=exp3:exp2
rst_active   CHECK 4 0 0 0 0 0 0000 0000 00000000 00000000 00000000 00000000
rst_rd_p0    READ  4 0 0 0 0 0 0000 0000 00000000 00000000 00000000 00000000
rst_rd_p1    READ  4 1 0 0 0 0 0000 0000 00000000 00000000 00000000 00000000
rst_rd_p2    READ  4 2 0 0 0 0 0000 0000 00000000 00000000 00000000 00000000
rst_rd_p3    READ  4 3 0 0 0 0 0000 0000 00000000 00000000 00000000 00000000
wr_p1        WRITE 4 1 11110001 22220001 00001001 0 ffff 0000 0 0 0 0
wr_p2        WRITE 4 2 11110002 22220002 00001002 0 ffff 0000 0 0 0 0
wr_p3        WRITE 4 3 11110003 22220003 00001003 0 ffff 0000 0 0 0 0
wr_rd_p1     READ  4 1 0 0 0 0 0000 0000 11110001 22220001 00001001 00000000
wr_rd_p2     READ  4 2 0 0 0 0 0000 0000 11110002 22220002 00001002 00000000
wr_rd_p3     READ  4 3 0 0 0 0 0000 0000 11110003 22220003 00001003 00000000
prot_tail    WRITE 4 1 aaaaaaaa bbbbbbbb 0000cccc 0 000f 0000 0 0 0 0
prot_part    WRITE 4 1 aaaaaaaa bbbbbbbb 0000cccc 0 7770 0000 0 0 0 0
prot_rd_p1   READ  4 1 0 0 0 0 0000 0000 11110001 22220001 00001001 00000000
rot_dma0     DMA   3 0 0 0 0 0 0000 0100 0 0 0 0
rot_chk_q1   CHECK 3 1 0 0 0 0 0000 0000 11110001 22220001 00001001 00000000
rot_rd_p0    READ  3 0 0 0 0 0 0000 0000 00000000 00000000 00000000 00000100
rot_dma1     DMA   3 0 0 0 0 0 0000 0200 0 0 0 0
rot_chk_q2   CHECK 3 2 0 0 0 0 0000 0000 11110002 22220002 00001002 00000000
rot_dma2     DMA   3 0 0 0 0 0 0000 0300 0 0 0 0
rot_chk_q0   CHECK 3 0 0 0 0 0 0000 0000 00000000 00000000 00000000 00000100
rot_rd_p2    READ  3 2 0 0 0 0 0000 0000 11110002 22220002 00001002 00000300
live_wr_p0   WRITE 3 0 44440000 33330000 00002000 0 ffff 0000 0 0 0 0
live_chk     CHECK 3 0 0 0 0 0 0000 0000 44440000 33330000 00002000 00000100
other_wr_p2  WRITE 3 2 55550000 66660000 00003000 0 ffff 0000 0 0 0 0
other_chk    CHECK 3 0 0 0 0 0 0000 0000 44440000 33330000 00002000 00000100
one_dma0     DMA   1 0 0 0 0 0 0000 0500 0 0 0 0
one_chk0     CHECK 1 0 0 0 0 0 0000 0000 44440000 33330000 00002000 00000500
one_dma1     DMA   1 0 0 0 0 0 0000 0600 0 0 0 0
one_chk1     CHECK 1 0 0 0 0 0 0000 0000 44440000 33330000 00002000 00000600
one_rd_p0    READ  1 0 0 0 0 0 0000 0000 44440000 33330000 00002000 00000600

// File: sim.f
source/queue_pkg.sv
source/queue_table_ram.sv
source/pio_regs.sv
source/queue_switcher.sv
source/pcie_queue_top.sv
test/queue_checker.sv
test/queue_scoreboard.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: pcie_queue

sources:
  - files:
      - source/queue_pkg.sv
      - source/queue_table_ram.sv
      - source/pio_regs.sv
      - source/queue_switcher.sv
      - source/pcie_queue_top.sv
  - target: test
    files:
      - test/queue_checker.sv
      - test/queue_scoreboard.sv
      - test/tb_top.sv
